// ==== command/cmd_decoder.sv ====
// frame-parsing FSM that turns received bytes into control strobes.
`timescale 1ns/100ps
`default_nettype none

module cmd_decoder (
	input  wire                        clk,
	input  wire                        rst,
	input  wire vec_pkg::byte_t        rx_data,
	input  wire                        rx_valid,
	output vec_pkg::cmd_ctrl_t         ctrl
);

	vec_pkg::rx_state_e    rx_state;
	vec_pkg::frame_state_e frame_state;
	vec_pkg::cmd_op_e      opcode;    // opcode of the frame in progress.
	vec_pkg::byte_t        rx_byte;   // byte under inspection.
	vec_pkg::len_t         len_field;

	// capture the byte while waiting.
	always_ff @(posedge clk) begin
		if (rx_state == vec_pkg::WAIT_BYTE && rx_valid) begin
			rx_byte <= rx_data;
		end
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			rx_state    <= vec_pkg::WAIT_BYTE;
			frame_state <= vec_pkg::IDLE_F;
			opcode      <= vec_pkg::CMD_SET_LEN;
		end else begin
			case (rx_state)
				vec_pkg::WAIT_BYTE: begin
					if (rx_valid) begin
						rx_state <= vec_pkg::CHECK_BYTE;
					end
				end

				vec_pkg::CHECK_BYTE: begin
					rx_state <= vec_pkg::WAIT_BYTE; // one byte per visit.
					case (frame_state)
						vec_pkg::IDLE_F: begin
							// anything but the start byte is discarded.
							if (rx_byte == vec_pkg::START_BYTE) begin
								frame_state <= vec_pkg::LENGTH_F;
							end
						end

						vec_pkg::LENGTH_F: begin
							frame_state <= vec_pkg::COMMAND_F; // length not checked.
						end

						vec_pkg::COMMAND_F: begin
							case (vec_pkg::cmd_op_e'(rx_byte))
								vec_pkg::CMD_SET_LEN,
								vec_pkg::CMD_START,
								vec_pkg::CMD_CLEAR,
								vec_pkg::CMD_PUSH_A,
								vec_pkg::CMD_PUSH_B: begin
									opcode      <= vec_pkg::cmd_op_e'(rx_byte);
									frame_state <= vec_pkg::PAYLOAD_F;
								end
								default: begin
									frame_state <= vec_pkg::IDLE_F; // unknown opcode.
								end
							endcase
						end

						vec_pkg::PAYLOAD_F: begin
							if (rx_byte == vec_pkg::END_BYTE) begin
								frame_state <= vec_pkg::IDLE_F;
							end
						end

						default: begin
							frame_state <= vec_pkg::IDLE_F;
						end
					endcase
				end

				default: begin
					rx_state <= vec_pkg::WAIT_BYTE;
				end
			endcase
		end
	end

	// a zero length is taken as one.
	assign len_field = (rx_byte[3:0] == 4'd0) ? 4'd1 : rx_byte[3:0];

	// strobes come out during the check cycle only.
	always_comb begin
		ctrl      = '0;
		ctrl.data = rx_byte;
		ctrl.len  = len_field;
		if (rx_state == vec_pkg::CHECK_BYTE && frame_state == vec_pkg::PAYLOAD_F) begin
			if (rx_byte == vec_pkg::END_BYTE) begin
				// start and clear act once, on the closing byte.
				case (opcode)
					vec_pkg::CMD_START: ctrl.start = 1'b1;
					vec_pkg::CMD_CLEAR: ctrl.clear = 1'b1;
					default: ;
				endcase
			end else begin
				case (opcode)
					vec_pkg::CMD_PUSH_A:  ctrl.push_a  = 1'b1;
					vec_pkg::CMD_PUSH_B:  ctrl.push_b  = 1'b1;
					vec_pkg::CMD_SET_LEN: ctrl.set_len = 1'b1; // last byte wins.
					default: ;
				endcase
			end
		end
	end

	// a byte goes to one store only.
	push_exclusive_a: assert property (
		@(posedge clk) disable iff (!rst)
		!(ctrl.push_a && ctrl.push_b)
	) else $error("push_a and push_b high together");

endmodule

`default_nettype wire

// ==== common/vec_pkg.sv ====
// byte codes, state and opcode enums, widths and the decoder control struct.
`default_nettype none

package vec_pkg;

	// one received or stored byte.
	typedef logic [7:0] byte_t;

	// frame delimiters.
	localparam byte_t START_BYTE = 8'hfe;
	localparam byte_t END_BYTE   = 8'hef;

	// command opcodes carried in the third byte of a frame.
	typedef enum logic [7:0] {
		CMD_SET_LEN = 8'h01,
		CMD_START   = 8'h02,
		CMD_CLEAR   = 8'h03,
		CMD_PUSH_A  = 8'h04,
		CMD_PUSH_B  = 8'h05
	} cmd_op_e;

	// byte capture state.
	typedef enum logic {
		WAIT_BYTE,
		CHECK_BYTE
	} rx_state_e;

	// position inside the current frame.
	typedef enum logic [1:0] {
		IDLE_F,
		LENGTH_F,
		COMMAND_F,
		PAYLOAD_F
	} frame_state_e;

	// vector length, 1 to 15.
	typedef logic [3:0] len_t;

	// accumulated dot product.
	typedef logic [23:0] result_t;

	// strobes and data from the decoder to the stores and the engine.
	typedef struct packed {
		logic  push_a;
		logic  push_b;
		byte_t data;
		logic  set_len;
		len_t  len;
		logic  start;
		logic  clear;
	} cmd_ctrl_t;

endpackage

`default_nettype wire

// ==== logic/dot_engine.sv ====
// dot-product engine that pops operand pairs and multiply-accumulates N of them.
`timescale 1ns/100ps
`default_nettype none

module dot_engine #(
	parameter int DEFAULT_LEN = 4
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire vec_pkg::cmd_ctrl_t ctrl,
	input  wire vec_pkg::byte_t     a_head,
	input  wire vec_pkg::byte_t     b_head,
	input  wire                     a_empty,
	input  wire                     b_empty,
	output logic                    pop,
	output vec_pkg::result_t        result,
	output logic                    result_valid,
	output logic                    busy
);

	vec_pkg::len_t    len_q;      // length for the next start.
	vec_pkg::len_t    remaining;  // pairs still to take.
	vec_pkg::result_t acc;
	logic [15:0]      product;
	logic             last_pair;

	// stall whenever either store runs dry.
	assign pop       = busy && !a_empty && !b_empty;
	assign product   = a_head * b_head;
	assign last_pair = pop && (remaining == 4'd1);
	assign result    = acc;

	// length register, read only at start.
	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			len_q <= vec_pkg::len_t'(DEFAULT_LEN);
		end else if (ctrl.set_len) begin
			len_q <= ctrl.len;
		end
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			busy         <= 1'b0;
			result_valid <= 1'b0;
			remaining    <= '0;
			acc          <= '0;
		end else begin
			result_valid <= 1'b0;
			if (ctrl.clear) begin
				busy      <= 1'b0;   // abort.
				remaining <= '0;
				acc       <= '0;
			end else if (!busy) begin
				if (ctrl.start) begin
					busy      <= 1'b1;
					remaining <= len_q;
					acc       <= '0;
				end
			end else if (pop) begin
				acc       <= acc + vec_pkg::result_t'(product);
				remaining <= remaining - 1'b1;
				if (last_pair) begin
					busy         <= 1'b0;
					result_valid <= 1'b1; // result valid with busy falling.
				end
			end
		end
	end

	// a result only closes a running computation.
	result_after_busy: assert property (
		@(posedge clk) disable iff (!rst)
		result_valid |-> $past(busy)
	) else $error("result_valid without a prior busy cycle");

endmodule

`default_nettype wire

// ==== logic/operand_fifo.sv ====
// circular byte FIFO for one operand vector with a sticky overflow flag.
`timescale 1ns/100ps
`default_nettype none

module operand_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 push,
	input  wire                 clear,
	input  wire vec_pkg::byte_t data,
	input  wire                 pop,
	output vec_pkg::byte_t      head,
	output logic                empty,
	output logic                overflow
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

	vec_pkg::byte_t mem [FIFO_DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [AW:0]    count;
	logic           full;
	logic           push_ok;

	assign full    = (count == FULL_COUNT);
	assign empty   = (count == '0);
	assign push_ok = push && !full;
	assign head    = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= data;
		end
	end

	// pointers wrap on their own, depth is a power of two.
	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else if (clear) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push_ok, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;  // both or neither.
			endcase
			if (push && full) begin
				overflow <= 1'b1; // held until clear.
			end
		end
	end

	// the engine must only pop a store with data in it.
	no_pop_when_empty: assert property (
		@(posedge clk) disable iff (!rst)
		pop |-> !empty
	) else $error("pop while FIFO empty");

endmodule

`default_nettype wire

// ==== logic/vec_top.sv ====
// top level joining the command decoder, two operand FIFOs and the dot engine.
`timescale 1ns/100ps
`default_nettype none

module vec_top #(
	parameter int FIFO_DEPTH  = 16,
	parameter int DEFAULT_LEN = 4
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire vec_pkg::byte_t rx_data,
	input  wire                 rx_valid,
	output vec_pkg::result_t    result,
	output logic                result_valid,
	output logic                busy,
	output logic                overflow
);

	vec_pkg::cmd_ctrl_t ctrl;
	vec_pkg::byte_t     a_head;
	vec_pkg::byte_t     b_head;
	logic               a_empty;
	logic               b_empty;
	logic               a_overflow;
	logic               b_overflow;
	logic               pop;  // shared by both stores.

	cmd_decoder decoder_i (
		.clk      (clk),
		.rst      (rst),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.ctrl     (ctrl)
	);

	operand_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_a_i (
		.clk      (clk),
		.rst      (rst),
		.push     (ctrl.push_a),
		.clear    (ctrl.clear),
		.data     (ctrl.data),
		.pop      (pop),
		.head     (a_head),
		.empty    (a_empty),
		.overflow (a_overflow)
	);

	operand_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_b_i (
		.clk      (clk),
		.rst      (rst),
		.push     (ctrl.push_b),
		.clear    (ctrl.clear),
		.data     (ctrl.data),
		.pop      (pop),
		.head     (b_head),
		.empty    (b_empty),
		.overflow (b_overflow)
	);

	dot_engine #(.DEFAULT_LEN(DEFAULT_LEN)) engine_i (
		.clk          (clk),
		.rst          (rst),
		.ctrl         (ctrl),
		.a_head       (a_head),
		.b_head       (b_head),
		.a_empty      (a_empty),
		.b_empty      (b_empty),
		.pop          (pop),
		.result       (result),
		.result_valid (result_valid),
		.busy         (busy)
	);

	assign overflow = a_overflow | b_overflow;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the vec_top testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vec_top.f --top-module vec_tb -Mdir obj_dir

out=$(./obj_dir/Vvec_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// ==== tests/vec_tb.sv ====
// testbench for vec_top with random frames, a reference model and result checks.
`timescale 1ns/100ps
`default_nettype none

module vec_tb;

	localparam int FIFO_DEPTH  = 16;
	localparam int DEFAULT_LEN = 4;
	localparam int TIMEOUT     = 2000;

	logic             clk;
	logic             rst;
	vec_pkg::byte_t   rx_data;
	logic             rx_valid;
	vec_pkg::result_t result;
	logic             result_valid;
	logic             busy;
	logic             overflow;

	// reference model state.
	vec_pkg::byte_t   q_a[$];
	vec_pkg::byte_t   q_b[$];
	vec_pkg::result_t exp_q[$];
	vec_pkg::byte_t   frame_q[$];  // payload of the next frame.
	logic             m_overflow;
	logic             m_busy;
	int               m_len;
	int               m_run_len;    // length latched at start.
	int               m_results;

	logic [31:0] seed;
	int          errors;
	int          timeouts;
	int          results;

	vec_top #(.FIFO_DEPTH(FIFO_DEPTH), .DEFAULT_LEN(DEFAULT_LEN)) dut_i (
		.clk          (clk),
		.rst          (rst),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.result       (result),
		.result_valid (result_valid),
		.busy         (busy),
		.overflow     (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic int rand_below(input int n);
		return int'(next_rand() % 32'(n));
	endfunction

	// any byte except the end code.
	function automatic vec_pkg::byte_t payload_byte();
		vec_pkg::byte_t b;
		b = vec_pkg::byte_t'(next_rand());
		if (b == vec_pkg::END_BYTE) begin
			b = 8'h00;
		end
		return b;
	endfunction

	// never opens a frame.
	function automatic vec_pkg::byte_t garbage_byte();
		vec_pkg::byte_t b;
		b = vec_pkg::byte_t'(next_rand());
		if (b == vec_pkg::START_BYTE) begin
			b = 8'h55;
		end
		return b;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic model_push(input logic to_b, input vec_pkg::byte_t b);
		if (to_b) begin
			if (q_b.size() < FIFO_DEPTH) begin
				q_b.push_back(b);
			end else begin
				m_overflow = 1'b1;
			end
		end else if (q_a.size() < FIFO_DEPTH) begin
			q_a.push_back(b);
		end else begin
			m_overflow = 1'b1;
		end
	endtask

	// finish the model run once both queues hold enough pairs.
	task automatic model_advance();
		vec_pkg::result_t sum;
		if (m_busy && q_a.size() >= m_run_len && q_b.size() >= m_run_len) begin
			sum = '0;
			for (int i = 0; i < m_run_len; i++) begin
				sum = sum + vec_pkg::result_t'(q_a.pop_front()) * vec_pkg::result_t'(q_b.pop_front());
			end
			exp_q.push_back(sum);
			m_results++;
			m_busy = 1'b0;
		end
	endtask

	task automatic send_byte(input vec_pkg::byte_t b);
		int gap;
		gap = 2 + rand_below(4);  // 2 to 5 cycles apart.
		@(posedge clk);
		rx_data  <= b;
		rx_valid <= 1'b1;
		@(posedge clk);
		rx_valid <= 1'b0;
		repeat (gap - 2) @(posedge clk);
	endtask

	// model is updated ahead of each byte so expectations lead the DUT.
	task automatic send_frame(input vec_pkg::cmd_op_e op);
		vec_pkg::byte_t b;
		send_byte(vec_pkg::START_BYTE);
		send_byte(8'(frame_q.size()));
		send_byte(op);
		while (frame_q.size() > 0) begin
			b = frame_q.pop_front();
			case (op)
				vec_pkg::CMD_PUSH_A:  model_push(1'b0, b);
				vec_pkg::CMD_PUSH_B:  model_push(1'b1, b);
				vec_pkg::CMD_SET_LEN: m_len = (b[3:0] == 4'd0) ? 1 : int'(b[3:0]);
				default: ;
			endcase
			model_advance();
			send_byte(b);
		end
		if (op == vec_pkg::CMD_START && !m_busy) begin
			m_busy    = 1'b1;
			m_run_len = m_len;
		end else if (op == vec_pkg::CMD_CLEAR) begin
			q_a.delete();
			q_b.delete();
			m_overflow = 1'b0;
			m_busy     = 1'b0;
		end
		model_advance();
		send_byte(vec_pkg::END_BYTE);
	endtask

	task automatic set_length(input int n);
		vec_pkg::byte_t lb;
		lb = {4'(rand_below(16)), 4'(n)};  // upper nibble is ignored.
		if (lb == vec_pkg::END_BYTE) begin
			lb = {4'h0, 4'(n)};
		end
		frame_q.push_back(lb);
		send_frame(vec_pkg::CMD_SET_LEN);
	endtask

	task automatic push_random(input vec_pkg::cmd_op_e op, input int n);
		repeat (n) frame_q.push_back(payload_byte());
		send_frame(op);
	endtask

	// start frames may carry junk payload.
	task automatic start_run();
		repeat (rand_below(3)) frame_q.push_back(payload_byte());
		send_frame(vec_pkg::CMD_START);
	endtask

	task automatic wait_results();
		int t;
		t = 0;
		while (results < m_results && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (results < m_results) begin
			$display("no result after start within %0d cycles", TIMEOUT);
			timeouts++;
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic check_overflow();
		repeat (3) @(posedge clk);
		@(negedge clk);
		check("overflow", 32'(overflow), 32'(m_overflow));
	endtask

	// every result is matched against the oldest expectation.
	always @(negedge clk) begin
		if (rst && result_valid) begin
			results++;
			check("busy", 32'(busy), 32'd0);
			if (exp_q.size() == 0) begin
				$display("result_valid with no computation pending");
				errors++;
			end else begin
				check("result", 32'(result), 32'(exp_q.pop_front()));
			end
		end
	end

	initial begin
		int len;
		int extra;
		int k;
		seed       = 32'he32683ea;
		errors     = 0;
		timeouts   = 0;
		results    = 0;
		m_overflow = 1'b0;
		m_busy     = 1'b0;
		m_len      = DEFAULT_LEN;
		m_run_len  = 0;
		m_results  = 0;
		rst        = 1'b0;
		rx_valid   = 1'b0;
		rx_data    = '0;

		// reset state.
		repeat (3) @(posedge clk);
		@(negedge clk);
		check("result_valid", 32'(result_valid), 32'd0);
		check("busy", 32'(busy), 32'd0);
		check("overflow", 32'(overflow), 32'd0);
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check("result_valid", 32'(result_valid), 32'd0);
		check("busy", 32'(busy), 32'd0);
		check("overflow", 32'(overflow), 32'd0);

		// basic dot products, the first at the reset length.
		for (int r = 0; r < 3; r++) begin
			if (r > 0) begin
				set_length(1 + rand_below(15));
			end
			push_random(vec_pkg::CMD_PUSH_A, m_len);
			push_random(vec_pkg::CMD_PUSH_B, m_len);
			start_run();
			wait_results();
		end

		// new length, B short at start, leftovers feed the next run.
		len   = 2 + rand_below(7);
		extra = 1 + rand_below(7);
		k     = 1 + rand_below(len);
		set_length(len);
		push_random(vec_pkg::CMD_PUSH_A, len + extra);
		push_random(vec_pkg::CMD_PUSH_B, len - k);
		start_run();
		repeat (20) @(posedge clk);
		@(negedge clk);
		check("busy", 32'(busy), 32'd1);  // stalled on B.
		push_random(vec_pkg::CMD_PUSH_B, k + extra);
		wait_results();
		set_length(extra);
		start_run();
		wait_results();

		// overflow and clear.
		send_frame(vec_pkg::CMD_CLEAR);
		check_overflow();
		push_random(vec_pkg::CMD_PUSH_A, FIFO_DEPTH + 4);
		check_overflow();
		push_random(vec_pkg::CMD_PUSH_B, 2);
		check_overflow();
		send_frame(vec_pkg::CMD_CLEAR);
		check_overflow();
		set_length(3);
		push_random(vec_pkg::CMD_PUSH_A, 3);
		push_random(vec_pkg::CMD_PUSH_B, 3);
		start_run();
		wait_results();

		// malformed traffic.
		repeat (3 + rand_below(4)) send_byte(garbage_byte());
		send_byte(vec_pkg::START_BYTE);
		send_byte(8'h03);
		send_byte(8'h10 + 8'(rand_below(64)));  // unknown opcode.
		repeat (3) send_byte(garbage_byte());
		send_byte(vec_pkg::END_BYTE);
		set_length(3);
		push_random(vec_pkg::CMD_PUSH_A, 3);
		push_random(vec_pkg::CMD_PUSH_B, 1);
		start_run();
		start_run();  // arrives while busy.
		push_random(vec_pkg::CMD_PUSH_B, 2);
		wait_results();
		push_random(vec_pkg::CMD_PUSH_A, 2);
		push_random(vec_pkg::CMD_PUSH_B, 2);
		set_length(2);
		start_run();
		wait_results();

		repeat (10) @(posedge clk);
		check("result_count", 32'(results), 32'(m_results));
		check("pending", 32'(exp_q.size()), 32'd0);
		$display("errors=%0d timeouts=%0d results=%0d", errors, timeouts, results);
		if (errors == 0 && timeouts == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vec_top.f ====
common/vec_pkg.sv
command/cmd_decoder.sv
logic/operand_fifo.sv
logic/dot_engine.sv
logic/vec_top.sv
tests/vec_tb.sv
